// File: hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // pc and instruction word width
  localparam int XLEN     = 32;
  localparam int OPCODE_W = 7;

  // major opcodes of the control transfers
  localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
  localparam logic [OPCODE_W-1:0] OP_JALR   = 7'b1100111;
  localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;

  // fence.i with imm, rs1 and rd all zero, funct3 = 001
  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  // reset vector
  localparam logic [XLEN-1:0] PC_INIT = 32'h8000_0000;

  // no compressed instructions, so a fixed step
  localparam logic [XLEN-1:0] INST_BYTES = 32'd4;

endpackage

`default_nettype wire

// File: hw/icache_pkg.sv
`default_nettype none

package icache_pkg;

  // direct-mapped geometry
  localparam int IC_SETS       = 4;
  localparam int IC_LINE_WORDS = 2;

  // address split is tag | index | word offset | byte
  localparam int IC_IDX_W = $clog2(IC_SETS);
  localparam int IC_OFF_W = $clog2(IC_LINE_WORDS);
  localparam int IC_TAG_W = rv_isa_pkg::XLEN - IC_IDX_W - IC_OFF_W - 2;

  // decode buffer depth seen by fetch
  localparam int FETCH_CREDITS = 4;
  // must hold the full count, not just count-1
  localparam int CREDIT_W      = $clog2(FETCH_CREDITS + 1);

endpackage

`default_nettype wire

// File: hw/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          credit_i,
  input  wire                          resolve_valid_i,
  input  wire  [rv_isa_pkg::XLEN-1:0]  resolve_npc_i,
  input  wire                          hit_i,
  input  wire  [rv_isa_pkg::XLEN-1:0]  hit_inst_i,
  output logic [rv_isa_pkg::XLEN-1:0]  lookup_pc_o,
  output logic                         invalidate_o,
  output logic                         inst_valid_o,
  output logic [rv_isa_pkg::XLEN-1:0]  inst_o,
  output logic [rv_isa_pkg::XLEN-1:0]  pc_o,
  output logic                         spec_o,
  output logic                         mispredict_o
);
  import rv_isa_pkg::*;
  import icache_pkg::*;

  logic [XLEN-1:0]     pc_q;
  logic [XLEN-1:0]     btb_q;
  logic                btb_valid_q;
  logic                pending_q;
  logic                predicted_q;
  logic [XLEN-1:0]     pred_target_q;
  logic                mispredict_q;
  logic [CREDIT_W-1:0] credit_q;

  logic [OPCODE_W-1:0] opcode;
  logic                is_ctrl;
  logic                is_fence;
  logic                stalled;
  logic                blocked;
  logic                deliver;
  logic                resolve;
  logic                wrong;

  assign opcode   = hit_inst_i[OPCODE_W-1:0];
  assign is_ctrl  = (opcode == OP_JAL) || (opcode == OP_JALR) || (opcode == OP_BRANCH);
  assign is_fence = (hit_inst_i == INST_FENCE_I);

  // pending with no guess, wait for the back end
  assign stalled = pending_q && !predicted_q;
  // second control transfer waits until the first one resolves
  assign blocked = pending_q && (is_ctrl || is_fence);
  assign deliver = hit_i && (credit_q != '0) && !stalled && !blocked;

  assign resolve = resolve_valid_i && pending_q;
  assign wrong   = resolve && predicted_q && (resolve_npc_i != pred_target_q);

  assign lookup_pc_o  = pc_q;
  assign inst_valid_o = deliver;
  assign inst_o       = hit_inst_i;
  assign pc_o         = pc_q;
  // the control instruction itself is not speculative, only what follows it
  assign spec_o       = deliver && predicted_q;
  assign invalidate_o = deliver && is_fence;
  assign mispredict_o = mispredict_q;

  // program counter
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= PC_INIT;
    end else if (resolve && (stalled || wrong)) begin
      pc_q <= resolve_npc_i;
    end else if (deliver) begin
      if (is_ctrl) begin
        // without a guess the pc holds until resolution
        if (btb_valid_q) begin
          pc_q <= btb_q;
        end
      end else if (!is_fence) begin
        pc_q <= pc_q + INST_BYTES;
      end
    end
  end

  // speculation tracking and target buffer valid
  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q    <= 1'b0;
      predicted_q  <= 1'b0;
      btb_valid_q  <= 1'b0;
      mispredict_q <= 1'b0;
    end else begin
      mispredict_q <= wrong;
      if (resolve) begin
        pending_q   <= 1'b0;
        predicted_q <= 1'b0;
        btb_valid_q <= 1'b1;
      end else if (deliver && (is_ctrl || is_fence)) begin
        pending_q   <= 1'b1;
        // fence.i never gets a guess
        predicted_q <= is_ctrl && btb_valid_q;
      end
    end
  end

  // target buffer and recorded guess
  always_ff @(posedge clk) begin
    if (resolve) begin
      btb_q <= resolve_npc_i;
    end
    if (deliver && is_ctrl && btb_valid_q) begin
      pred_target_q <= btb_q;
    end
  end

  // credits toward the decode buffer
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_q <= CREDIT_W'(FETCH_CREDITS);
    end else begin
      case ({deliver, credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: credit_q <= credit_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/l1i_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1i_cache (
  input  wire                          clk,
  input  wire                          rst,
  input  wire  [rv_isa_pkg::XLEN-1:0]  lookup_pc_i,
  input  wire                          take_i,
  input  wire                          invalidate_i,
  input  wire                          mem_rvalid_i,
  input  wire  [rv_isa_pkg::XLEN-1:0]  mem_rdata_i,
  output logic                         hit_o,
  output logic [rv_isa_pkg::XLEN-1:0]  hit_inst_o,
  output logic                         mem_req_o,
  output logic [rv_isa_pkg::XLEN-1:0]  mem_addr_o
);
  import rv_isa_pkg::*;
  import icache_pkg::*;

  typedef enum logic [2:0] {
    FILL_IDLE,
    FILL_REQ0,
    FILL_GAP,
    FILL_REQ1,
    FILL_DONE
  } fill_state_e;

  fill_state_e         state_q;

  logic [XLEN-1:0]     data_q [IC_SETS][IC_LINE_WORDS];
  logic [IC_TAG_W-1:0] tag_q [IC_SETS];
  logic [IC_SETS-1:0]  valid_q;

  // line address latched at fill start, pc may move during the fill
  logic [IC_TAG_W-1:0] fill_tag_q;
  logic [IC_IDX_W-1:0] fill_idx_q;
  logic                fill_stale_q;

  logic [IC_TAG_W-1:0] pc_tag;
  logic [IC_IDX_W-1:0] pc_idx;
  logic [IC_OFF_W-1:0] pc_off;
  logic [IC_OFF_W-1:0] fill_off;
  logic                filling;
  logic                clear_all;

  assign pc_tag = lookup_pc_i[XLEN-1 -: IC_TAG_W];
  assign pc_idx = lookup_pc_i[2+IC_OFF_W +: IC_IDX_W];
  assign pc_off = lookup_pc_i[2 +: IC_OFF_W];

  assign hit_o      = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign hit_inst_o = data_q[pc_idx][pc_off];

  // flush only once the fence.i is actually consumed
  assign clear_all = invalidate_i && take_i;
  assign filling   = (state_q != FILL_IDLE);

  assign fill_off   = (state_q == FILL_REQ1) ? IC_OFF_W'(1) : '0;
  assign mem_req_o  = (state_q == FILL_REQ0) || (state_q == FILL_REQ1);
  assign mem_addr_o = {fill_tag_q, fill_idx_q, fill_off, 2'b00};

  // fill FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FILL_IDLE;
    end else begin
      case (state_q)
        FILL_IDLE: begin
          if (!hit_o) begin
            state_q <= FILL_REQ0;
          end
        end
        FILL_REQ0: begin
          if (mem_rvalid_i) begin
            state_q <= FILL_GAP;
          end
        end
        FILL_GAP: begin
          state_q <= FILL_REQ1;
        end
        FILL_REQ1: begin
          if (mem_rvalid_i) begin
            state_q <= FILL_DONE;
          end
        end
        FILL_DONE: begin
          state_q <= FILL_IDLE;
        end
        default: begin
          state_q <= FILL_IDLE;
        end
      endcase
    end
  end

  // valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q      <= '0;
      fill_stale_q <= 1'b0;
    end else begin
      if (!filling) begin
        fill_stale_q <= 1'b0;
      end else if (clear_all) begin
        // words read before the flush must not come back valid
        fill_stale_q <= 1'b1;
      end
      if (clear_all) begin
        valid_q <= '0;
      end else if (state_q == FILL_IDLE && !hit_o) begin
        // old line in this set is overwritten word by word
        valid_q[pc_idx] <= 1'b0;
      end else if (state_q == FILL_REQ1 && mem_rvalid_i && !fill_stale_q) begin
        valid_q[fill_idx_q] <= 1'b1;
      end
    end
  end

  // data, tag and fill address
  always_ff @(posedge clk) begin
    if (state_q == FILL_IDLE) begin
      fill_tag_q <= pc_tag;
      fill_idx_q <= pc_idx;
    end
    if (mem_req_o && mem_rvalid_i) begin
      data_q[fill_idx_q][fill_off] <= mem_rdata_i;
    end
    // tag goes in with the last word
    if (state_q == FILL_REQ1 && mem_rvalid_i) begin
      tag_q[fill_idx_q] <= fill_tag_q;
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch_top (
  input  wire                          clk,
  input  wire                          rst,

  // decode side
  output logic                         inst_valid_o,
  output logic [rv_isa_pkg::XLEN-1:0]  inst_o,
  output logic [rv_isa_pkg::XLEN-1:0]  pc_o,
  output logic                         spec_o,
  input  wire                          credit_i,

  // resolution from the back end
  input  wire                          resolve_valid_i,
  input  wire  [rv_isa_pkg::XLEN-1:0]  resolve_npc_i,
  output logic                         mispredict_o,

  // instruction memory
  output logic                         mem_req_o,
  output logic [rv_isa_pkg::XLEN-1:0]  mem_addr_o,
  input  wire                          mem_rvalid_i,
  input  wire  [rv_isa_pkg::XLEN-1:0]  mem_rdata_i
);
  import rv_isa_pkg::*;

  logic [XLEN-1:0] lookup_pc;
  logic            hit;
  logic [XLEN-1:0] hit_inst;
  logic            invalidate;

  fetch_ctrl u_fetch_ctrl (
    .clk             (clk),
    .rst             (rst),
    .credit_i        (credit_i),
    .resolve_valid_i (resolve_valid_i),
    .resolve_npc_i   (resolve_npc_i),
    .hit_i           (hit),
    .hit_inst_i      (hit_inst),
    .lookup_pc_o     (lookup_pc),
    .invalidate_o    (invalidate),
    .inst_valid_o    (inst_valid_o),
    .inst_o          (inst_o),
    .pc_o            (pc_o),
    .spec_o          (spec_o),
    .mispredict_o    (mispredict_o)
  );

  // a delivered instruction is what the cache sees as take
  l1i_cache u_l1i_cache (
    .clk          (clk),
    .rst          (rst),
    .lookup_pc_i  (lookup_pc),
    .take_i       (inst_valid_o),
    .invalidate_i (invalidate),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .hit_o        (hit),
    .hit_inst_o   (hit_inst),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o)
  );

endmodule

`default_nettype wire

// File: tests/fetch_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_mem_model (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          req_i,
  input  wire  [rv_isa_pkg::XLEN-1:0]  addr_i,
  output logic                         rvalid_o,
  output logic [rv_isa_pkg::XLEN-1:0]  rdata_o,
  input  wire  [rv_isa_pkg::XLEN-1:0]  peek_addr_i,
  output logic [rv_isa_pkg::XLEN-1:0]  peek_data_o
);
  import rv_isa_pkg::*;

  logic [15:0] lfsr = 16'd16;
  logic        busy;
  logic [1:0]  wait_cnt;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // fixed program, straight-line addi everywhere else
  function automatic logic [XLEN-1:0] prog_word(input logic [XLEN-1:0] addr);
    case (addr)
      32'h8000_0010: return 32'h0300_006f;
      // bne x1, x0, back
      32'h8000_0048: return 32'hfe00_9ce3;
      32'h8000_004c: return INST_FENCE_I;
      // addi x1, x0, word index
      default:       return 32'h0000_0093 | {addr[13:2], 20'h0_0000};
    endcase
  endfunction

  // second read port, used by the checker only
  assign peek_data_o = prog_word(peek_addr_i);

  always @(posedge clk) begin
    logic [1:0] lat;
    if (rst) begin
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
      busy     <= 1'b0;
      wait_cnt <= '0;
    end else if (rvalid_o) begin
      rvalid_o <= 1'b0;
      busy     <= 1'b0;
    end else if (busy) begin
      if (wait_cnt == 0) begin
        rvalid_o <= 1'b1;
        rdata_o  <= prog_word(addr_i);
      end else begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end else if (req_i) begin
      // two random bits give 1 to 4 cycles
      lfsr   = lfsr_step(lfsr);
      lat[0] = lfsr[0];
      lfsr   = lfsr_step(lfsr);
      lat[1] = lfsr[0];
      busy     <= 1'b1;
      wait_cnt <= lat;
    end
  end

endmodule

`default_nettype wire

// File: tests/rv_fetch_sva.sv
`timescale 1ns/1ps
`default_nettype none

module rv_fetch_sva (
  input wire                          clk,
  input wire                          rst,
  input wire                          inst_valid_o,
  input wire                          spec_o,
  input wire                          mispredict_o,
  input wire                          credit_i,
  input wire                          mem_req_o,
  input wire  [rv_isa_pkg::XLEN-1:0]  mem_addr_o,
  input wire                          mem_rvalid_i
);
  import icache_pkg::*;

  int   outstanding;
  int   fail_count = 0;
  logic in_reset_q;

  // deliveries not yet returned by the decode buffer
  always @(posedge clk) begin
    in_reset_q <= rst;
    if (rst) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + (inst_valid_o ? 1 : 0) - (credit_i ? 1 : 0);
    end
  end

  a_no_credit: assert property (@(posedge clk) disable iff (rst)
    inst_valid_o |-> outstanding < FETCH_CREDITS)
    else begin
      $error("delivery with no credit left");
      fail_count++;
    end

  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    outstanding <= FETCH_CREDITS)
    else begin
      $error("outstanding deliveries above buffer depth");
      fail_count++;
    end

  a_mem_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req_o && !mem_rvalid_i |=> mem_req_o && $stable(mem_addr_o))
    else begin
      $error("memory request dropped or address moved");
      fail_count++;
    end

  a_reset_quiet: assert property (@(posedge clk)
    rst && in_reset_q |-> !inst_valid_o && !spec_o && !mispredict_o && !mem_req_o)
    else begin
      $error("output active during reset");
      fail_count++;
    end

endmodule

bind rv_fetch_top rv_fetch_sva u_sva (
  .clk          (clk),
  .rst          (rst),
  .inst_valid_o (inst_valid_o),
  .spec_o       (spec_o),
  .mispredict_o (mispredict_o),
  .credit_i     (credit_i),
  .mem_req_o    (mem_req_o),
  .mem_addr_o   (mem_addr_o),
  .mem_rvalid_i (mem_rvalid_i)
);

`default_nettype wire

// File: tests/tb_rv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_fetch;
  import rv_isa_pkg::*;
  import icache_pkg::*;

  localparam int          RUN_TIMEOUT = 4000;
  localparam logic [31:0] LAST_PC     = 32'h8000_005c;
  localparam logic [31:0] BRANCH_PC   = 32'h8000_0048;

  logic            clk = 1'b0;
  logic            rst;
  logic            credit_i;
  logic            resolve_valid_i;
  logic [XLEN-1:0] resolve_npc_i;
  logic            inst_valid_o;
  logic [XLEN-1:0] inst_o;
  logic [XLEN-1:0] pc_o;
  logic            spec_o;
  logic            mispredict_o;
  logic            mem_req_o;
  logic [XLEN-1:0] mem_addr_o;
  logic            mem_rvalid_i;
  logic [XLEN-1:0] mem_rdata_i;
  logic [XLEN-1:0] table_inst;

  logic [15:0] lfsr = 16'd16;
  int          errors = 0;
  int          sva_fails;
  int          cycles;
  int          held = 0;
  int          branch_visits = 0;
  logic        done = 1'b0;
  logic        fence_seen = 1'b0;
  logic        refill_seen = 1'b0;

  // reference model of the fetch rules
  logic [XLEN-1:0] exp_pc = PC_INIT;
  logic [XLEN-1:0] exp_pred_target;
  logic [XLEN-1:0] exp_btb;
  logic            exp_btb_valid = 1'b0;
  logic            exp_predicted = 1'b0;
  logic            exp_stalled = 1'b0;
  logic            misp_due = 1'b0;

  // back end resolution queue of depth one
  logic            res_armed = 1'b0;
  logic [2:0]      res_delay;
  logic [XLEN-1:0] res_npc;

  always #50 clk = ~clk;

  rv_fetch_top dut (
    .clk             (clk),
    .rst             (rst),
    .inst_valid_o    (inst_valid_o),
    .inst_o          (inst_o),
    .pc_o            (pc_o),
    .spec_o          (spec_o),
    .credit_i        (credit_i),
    .resolve_valid_i (resolve_valid_i),
    .resolve_npc_i   (resolve_npc_i),
    .mispredict_o    (mispredict_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_rdata_i     (mem_rdata_i)
  );

  fetch_mem_model u_mem (
    .clk         (clk),
    .rst         (rst),
    .req_i       (mem_req_o),
    .addr_i      (mem_addr_o),
    .rvalid_o    (mem_rvalid_i),
    .rdata_o     (mem_rdata_i),
    .peek_addr_i (pc_o),
    .peek_data_o (table_inst)
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic next_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b    = lfsr[0];
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    errors++;
    $display("ERR %s expected %h got %h", name, exp, got);
  endtask

  // true next pc that the back end reports on each visit
  function automatic logic [XLEN-1:0] resolve_target(input logic [XLEN-1:0] pc, input int visit);
    case (pc)
      32'h8000_0010: return 32'h8000_0040;
      32'h8000_004c: return 32'h8000_0040;
      BRANCH_PC: begin
        if (visit == 1) return 32'h8000_0040;
        if (visit == 2) return 32'h8000_004c;
        return 32'h8000_0050;
      end
      default: return pc + 4;
    endcase
  endfunction

  // checker and reference model sample at the falling edge
  always @(negedge clk) begin
    logic b;
    logic is_ctrl;
    logic is_fence;
    if (!rst) begin
      assert (mispredict_o == misp_due)
        else value_mismatch("mispredict_o", misp_due, mispredict_o);
      misp_due = 1'b0;
      if (inst_valid_o) begin
        is_fence = (inst_o == INST_FENCE_I);
        is_ctrl  = (inst_o[6:0] == OP_JAL) || (inst_o[6:0] == OP_JALR) ||
                   (inst_o[6:0] == OP_BRANCH);
        assert (!exp_stalled) else begin
          errors++;
          $display("instruction delivered while fetch should wait for a resolution");
        end
        assert (pc_o == exp_pc) else value_mismatch("pc_o", exp_pc, pc_o);
        assert (inst_o == table_inst) else value_mismatch("inst_o", table_inst, inst_o);
        assert (spec_o == exp_predicted) else value_mismatch("spec_o", exp_predicted, spec_o);
        held++;
        if (pc_o == BRANCH_PC) begin
          branch_visits++;
        end
        if (is_fence) begin
          exp_stalled = 1'b1;
          fence_seen  = 1'b1;
          refill_seen = 1'b0;
        end else if (is_ctrl) begin
          if (exp_btb_valid) begin
            exp_predicted   = 1'b1;
            exp_pred_target = exp_btb;
            exp_pc          = exp_btb;
          end else begin
            exp_stalled = 1'b1;
          end
        end else begin
          exp_pc = exp_pc + 4;
        end
        if (is_fence || is_ctrl) begin
          res_npc = resolve_target(pc_o, branch_visits);
          for (int i = 0; i < 3; i++) begin
            next_bit(b);
            res_delay[i] = b;
          end
          res_armed = 1'b1;
        end
        if (pc_o == LAST_PC) begin
          done = 1'b1;
        end
      end
      if (resolve_valid_i) begin
        if (exp_predicted && resolve_npc_i != exp_pred_target) begin
          misp_due = 1'b1;
          exp_pc   = resolve_npc_i;
        end else if (exp_stalled) begin
          exp_pc = resolve_npc_i;
        end
        exp_btb       = resolve_npc_i;
        exp_btb_valid = 1'b1;
        exp_predicted = 1'b0;
        exp_stalled   = 1'b0;
      end
      if (fence_seen && mem_req_o && mem_addr_o == 32'h8000_0040) begin
        refill_seen = 1'b1;
      end
    end
  end

  // back end model returns credits and resolves control transfers
  always @(posedge clk) begin
    logic b;
    if (rst) begin
      credit_i        <= 1'b0;
      resolve_valid_i <= 1'b0;
    end else begin
      next_bit(b);
      // credits go back only once the decode buffer is nearly full
      if (held >= FETCH_CREDITS - 1 && b) begin
        credit_i <= 1'b1;
        held--;
      end else begin
        credit_i <= 1'b0;
      end
      resolve_valid_i <= 1'b0;
      if (res_armed) begin
        if (res_delay == 0) begin
          resolve_valid_i <= 1'b1;
          resolve_npc_i   <= res_npc;
          res_armed = 1'b0;
        end else begin
          res_delay = res_delay - 1'b1;
        end
      end
    end
  end

  initial begin
    rst             = 1'b1;
    credit_i        = 1'b0;
    resolve_valid_i = 1'b0;
    resolve_npc_i   = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    for (cycles = 0; cycles < RUN_TIMEOUT && !done; cycles++) begin
      @(posedge clk);
    end
    if (!done) begin
      errors++;
      $display("timeout: fetch never reached the last instruction of the program");
    end
    if (!refill_seen) begin
      errors++;
      $display("no memory request for 0x80000040 after fence.i");
    end
    sva_fails = dut.u_sva.fail_count;
    $display("errors: %0d, assertion failures: %0d", errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_fetch.f
hw/rv_isa_pkg.sv
hw/icache_pkg.sv
hw/fetch_ctrl.sv
hw/l1i_cache.sv
hw/rv_fetch_top.sv
tests/fetch_mem_model.sv
tests/rv_fetch_sva.sv
tests/tb_rv_fetch.sv
